// File: bench/bt_link_tb.sv
`timescale 1ns/1ns

module bt_link_tb
	import link_pkg::*;
	import uart_pkg::*;
;

	localparam int CPB = 4;
	localparam int GAP_LEN = 6;
	localparam int FRAME_LEN = FRAME_BITS * CPB;
	localparam int SETTLE = 3 * (FRAME_LEN + GAP_LEN);
	localparam int NUM_TESTS = 6;
	localparam logic [1:0] KIND_IDLE = 2'd0;
	localparam logic [1:0] KIND_STREAM = 2'd1;
	localparam logic [1:0] KIND_AT = 2'd2;

	// One row of the stimulus table
	typedef struct packed
	{
		logic [1:0] kind;
		stream_mask_t mask;
		logic [2:0] rounds;
		logic access_early;
		logic [2:0] n_chars;
		logic [31:0] chars;
	} test_t;

	logic clock = 1'b0;
	logic reset;
	stream_mask_t stream_valid;
	sample_t stream_data [NUM_STREAMS];
	logic access_datastreams;
	logic want_at;
	tx_byte_t at_char;
	logic at_load;
	logic at_ack;
	logic at_done;
	cycle_count_t cycles_per_bit;
	cycle_count_t gap_cycles;
	logic fpga_txd;
	logic at_stored;

	test_t tests [NUM_TESTS];
	string names [NUM_TESTS];
	tx_byte_t rx_q [$];
	tx_byte_t exp_q [$];
	sample_t model_mem [NUM_STREAMS][STREAM_DEPTH];
	int model_cnt [NUM_STREAMS];
	int last_served = 0;
	integer seed = 32'h93b65c7a;
	int cycle_no = 0;
	int frames_begun = 0;
	int error_count = 0;
	int check_count = 0;
	int failed_tests = 0;
	string cur_name = "reset";
	logic table_ready = 1'b0;

	bt_link_top dut0
	(
		.clock(clock),
		.reset(reset),
		.stream_valid(stream_valid),
		.stream_data(stream_data),
		.access_datastreams(access_datastreams),
		.want_at(want_at),
		.at_char(at_char),
		.at_load(at_load),
		.at_ack(at_ack),
		.at_done(at_done),
		.cycles_per_bit(cycles_per_bit),
		.gap_cycles(gap_cycles),
		.fpga_txd(fpga_txd),
		.at_stored(at_stored)
	);

	always #2 clock = ~clock;

	always @(posedge clock)
		cycle_no <= cycle_no + 1;

	function automatic test_t make_test(logic [1:0] kind, stream_mask_t mask,
		logic [2:0] rounds, logic early, logic [2:0] n_chars, logic [31:0] chars);
		test_t t;
		t.kind = kind;
		t.mask = mask;
		t.rounds = rounds;
		t.access_early = early;
		t.n_chars = n_chars;
		t.chars = chars;
		return t;
	endfunction

	task automatic fill_table();
		names[0] = "reset_idle";
		tests[0] = make_test(KIND_IDLE, 8'h00, 3'd0, 1'b0, 3'd0, 32'h0);
		names[1] = "single_sample";
		tests[1] = make_test(KIND_STREAM, 8'h10, 3'd1, 1'b1, 3'd0, 32'h0);
		names[2] = "round_robin";
		tests[2] = make_test(KIND_STREAM, 8'hA5, 3'd3, 1'b1, 3'd0, 32'h0);
		names[3] = "held_streams";
		tests[3] = make_test(KIND_STREAM, 8'h62, 3'd2, 1'b0, 3'd0, 32'h0);
		// "AT+X" with two streams waiting behind it
		names[4] = "at_batch";
		tests[4] = make_test(KIND_AT, 8'h09, 3'd1, 1'b1, 3'd4, 32'h41542B58);
		names[5] = "stream_overflow";
		tests[5] = make_test(KIND_STREAM, 8'h04, 3'd6, 1'b0, 3'd0, 32'h0);
	endtask

	task automatic check_byte(string what, tx_byte_t expected, tx_byte_t actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("ERR %s %s: expected %h, actual %h", cur_name, what, expected, actual);
		end
	endtask

	task automatic check_flag(string what, logic expected, logic actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("ERR %s %s: expected %b, actual %b", cur_name, what, expected, actual);
		end
	endtask

	task automatic check_gap(int gap);
		check_count++;
		if (gap < GAP_LEN)
		begin
			error_count++;
			$display("%s: line idle for only %0d cycles between frames, %0d required",
				cur_name, gap, GAP_LEN);
		end
	endtask

	task automatic check_silence(string when, int allowed);
		check_count++;
		if (frames_begun != allowed)
		begin
			error_count++;
			$display("%s: %0d frames were started %s, only %0d allowed",
				cur_name, frames_begun, when, allowed);
		end
	endtask

	// Each round writes every stream of the mask in the same cycle
	task automatic write_rounds(stream_mask_t mask, logic [2:0] rounds);
		integer rnd;
		for (int r = 0; r < int'(rounds); r++)
		begin
			@(posedge clock);
			stream_valid <= mask;
			for (int i = 0; i < NUM_STREAMS; i++)
			begin
				if (mask[i])
				begin
					rnd = $random(seed);
					stream_data[i] <= rnd[15:0];
					if (model_cnt[i] < STREAM_DEPTH)
					begin
						model_mem[i][model_cnt[i]] = rnd[15:0];
						model_cnt[i]++;
					end
				end
			end
		end
		@(posedge clock);
		stream_valid <= '0;
	endtask

	// Expected bytes in rotation upward from the last served stream
	task automatic build_stream_order();
		int rd [NUM_STREAMS];
		int left;
		int s;
		left = 0;
		s = 0;
		for (int i = 0; i < NUM_STREAMS; i++)
		begin
			rd[i] = 0;
			left += model_cnt[i];
		end
		while (left > 0)
		begin
			for (int k = 1; k <= NUM_STREAMS; k++)
			begin
				s = (last_served + k) % NUM_STREAMS;
				if (rd[s] < model_cnt[s])
					break;
			end
			exp_q.push_back(model_mem[s][rd[s]][15:8]);
			exp_q.push_back(model_mem[s][rd[s]][7:0]);
			rd[s]++;
			left--;
			last_served = s;
		end
	endtask

	task automatic load_char(tx_byte_t ch, logic last);
		@(posedge clock);
		at_char <= ch;
		at_load <= 1'b1;
		@(posedge clock);
		@(negedge clock);
		check_flag("at_stored after load", 1'b1, at_stored);
		if (last)
			check_silence("before at_done", 0);
		@(posedge clock);
		at_load <= 1'b0;
		at_ack <= 1'b1;
		at_done <= last;
		@(posedge clock);
		@(negedge clock);
		check_flag("at_stored after ack", 1'b0, at_stored);
		@(posedge clock);
		at_ack <= 1'b0;
		at_done <= 1'b0;
	endtask

	task automatic wait_frames(int n);
		while (rx_q.size() < n)
			@(negedge clock);
	endtask

	task automatic finish_test();
		wait_frames(exp_q.size());
		// Extra frames would show up in this window
		repeat (SETTLE) @(negedge clock);
		check_count++;
		if (rx_q.size() != exp_q.size())
		begin
			error_count++;
			$display("%s: %0d frames expected but %0d received",
				cur_name, exp_q.size(), rx_q.size());
		end
		else
		begin
			for (int k = 0; k < exp_q.size(); k++)
				check_byte($sformatf("frame %0d", k), exp_q[k], rx_q[k]);
		end
	endtask

	task automatic run_test(int t);
		test_t cur;
		int errors_before;
		cur = tests[t];
		cur_name = names[t];
		errors_before = error_count;
		rx_q.delete();
		exp_q.delete();
		frames_begun = 0;
		for (int i = 0; i < NUM_STREAMS; i++)
			model_cnt[i] = 0;
		case (cur.kind)
			KIND_IDLE:
			begin
				@(negedge clock);
				check_flag("line level", 1'b1, fpga_txd);
				check_flag("at_stored", 1'b0, at_stored);
			end
			KIND_STREAM:
			begin
				@(posedge clock);
				access_datastreams <= cur.access_early;
				write_rounds(cur.mask, cur.rounds);
				build_stream_order();
				if (!cur.access_early)
				begin
					repeat (SETTLE) @(negedge clock);
					check_silence("while access_datastreams was low", 0);
					@(posedge clock);
					access_datastreams <= 1'b1;
				end
			end
			default:
			begin
				@(posedge clock);
				want_at <= 1'b1;
				access_datastreams <= 1'b1;
				write_rounds(cur.mask, cur.rounds);
				for (int k = 0; k < int'(cur.n_chars); k++)
					exp_q.push_back(cur.chars[31 - 8 * k -: 8]);
				build_stream_order();
				for (int k = 0; k < int'(cur.n_chars); k++)
					load_char(cur.chars[31 - 8 * k -: 8], k == int'(cur.n_chars) - 1);
				wait_frames(int'(cur.n_chars));
				// Waiting streams must stay queued while want_at is high
				repeat (SETTLE) @(negedge clock);
				check_silence("while want_at was high", int'(cur.n_chars));
				@(posedge clock);
				want_at <= 1'b0;
			end
		endcase
		finish_test();
		@(posedge clock);
		access_datastreams <= 1'b0;
		$display("test %s finished with %0d errors", cur_name, error_count - errors_before);
		if (error_count != errors_before)
			failed_tests++;
	endtask

	// Serial decoder sampling each bit at its middle
	initial
	begin : decoder
		tx_byte_t rx;
		int frame_start;
		int last_end;
		logic have_frame;
		have_frame = 1'b0;
		last_end = 0;
		rx = '0;
		wait (reset === 1'b0);
		forever
		begin
			@(negedge clock);
			if (fpga_txd === 1'b0)
			begin
				frame_start = cycle_no;
				frames_begun++;
				if (have_frame)
					check_gap(frame_start - last_end);
				repeat (CPB / 2) @(negedge clock);
				check_flag("start bit", 1'b0, fpga_txd);
				for (int k = 0; k < 8; k++)
				begin
					repeat (CPB) @(negedge clock);
					rx[k] = fpga_txd;
				end
				repeat (CPB) @(negedge clock);
				check_flag("stop bit", 1'b1, fpga_txd);
				rx_q.push_back(rx);
				last_end = frame_start + FRAME_LEN;
				have_frame = 1'b1;
				repeat (CPB - CPB / 2 - 1) @(negedge clock);
			end
		end
	end

	initial
	begin : watchdog
		int items;
		int limit;
		wait (table_ready);
		items = 0;
		for (int t = 0; t < NUM_TESTS; t++)
			items += 2 * $countones(tests[t].mask) * int'(tests[t].rounds)
				+ int'(tests[t].n_chars);
		limit = 2 * (items * 3 * (FRAME_LEN + GAP_LEN) + NUM_TESTS * 4 * SETTLE);
		repeat (limit) @(posedge clock);
		$display("Timeout: the tests did not finish within %0d cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		fill_table();
		table_ready = 1'b1;
		reset <= 1'b1;
		stream_valid <= '0;
		for (int i = 0; i < NUM_STREAMS; i++)
			stream_data[i] <= '0;
		access_datastreams <= 1'b0;
		want_at <= 1'b0;
		at_char <= '0;
		at_load <= 1'b0;
		at_ack <= 1'b0;
		at_done <= 1'b0;
		cycles_per_bit <= cycle_count_t'(CPB);
		gap_cycles <= cycle_count_t'(GAP_LEN);
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		repeat (2) @(posedge clock);
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			NUM_TESTS, failed_tests, check_count, error_count);
		if (error_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: bt_link_top.f
logic/link_pkg.sv
logic/uart_pkg.sv
logic/uart_tx.sv
logic/stream_buffer.sv
logic/at_buffer.sv
logic/link_controller.sv
logic/bt_link_top.sv
bench/bt_link_tb.sv

// File: logic/at_buffer.sv
`timescale 1ns/1ns

module at_buffer
	import link_pkg::*;
	import uart_pkg::*;
(
	input logic clock,
	input logic reset,
	input tx_byte_t at_char,
	input logic at_load,
	input logic at_ack,
	input logic at_done,
	input logic at_pop,
	output logic at_stored,
	output at_head_t at_head
);

	tx_byte_t at_mem [AT_DEPTH];
	logic [AT_PTR_W-1:0] wr_ptr;
	logic [AT_PTR_W-1:0] rd_ptr;
	logic [AT_CNT_W-1:0] count;
	logic [AT_CNT_W-1:0] count_next;
	logic batch_ready;
	logic load_req;
	logic ack_req;
	logic push;
	logic pop;

	// User handshake: store on load, release on ack
	assign load_req = !at_stored && at_load;
	assign ack_req = at_stored && at_ack;

	// Full FIFO swallows the character, handshake still completes
	assign push = load_req && (count != AT_CNT_W'(AT_DEPTH));
	assign pop = at_pop && (count != '0);
	assign count_next = count + AT_CNT_W'(push) - AT_CNT_W'(pop);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			at_stored <= 1'b0;
			batch_ready <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;

			if (load_req)
				at_stored <= 1'b1;
			else if (ack_req)
				at_stored <= 1'b0;

			// Batch stays released until drained
			if (ack_req && at_done)
				batch_ready <= 1'b1;
			else if (count_next == '0)
				batch_ready <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (push)
			at_mem[wr_ptr] <= at_char;
	end

	assign at_head.present = (count != '0);
	assign at_head.batch_ready = batch_ready;
	assign at_head.char = at_mem[rd_ptr];

endmodule

// File: logic/bt_link_top.sv
`timescale 1ns/1ns

module bt_link_top
	import link_pkg::*;
	import uart_pkg::*;
(
	input logic clock,
	input logic reset,
	input stream_mask_t stream_valid,
	input sample_t stream_data [NUM_STREAMS],
	input logic access_datastreams,
	input logic want_at,
	input tx_byte_t at_char,
	input logic at_load,
	input logic at_ack,
	input logic at_done,
	input cycle_count_t cycles_per_bit,
	input cycle_count_t gap_cycles,
	output logic fpga_txd,
	output logic at_stored
);

	stream_head_t stream_head;
	at_head_t at_head;
	logic stream_pop;
	logic at_pop;

	stream_buffer u_streams
	(
		.clock(clock),
		.reset(reset),
		.stream_valid(stream_valid),
		.stream_data(stream_data),
		.stream_pop(stream_pop),
		.stream_head(stream_head)
	);

	at_buffer u_at
	(
		.clock(clock),
		.reset(reset),
		.at_char(at_char),
		.at_load(at_load),
		.at_ack(at_ack),
		.at_done(at_done),
		.at_pop(at_pop),
		.at_stored(at_stored),
		.at_head(at_head)
	);

	link_controller u_ctrl
	(
		.clock(clock),
		.reset(reset),
		.want_at(want_at),
		.access_datastreams(access_datastreams),
		.stream_head(stream_head),
		.at_head(at_head),
		.cycles_per_bit(cycles_per_bit),
		.gap_cycles(gap_cycles),
		.stream_pop(stream_pop),
		.at_pop(at_pop),
		.fpga_txd(fpga_txd)
	);

endmodule

// File: logic/link_controller.sv
`timescale 1ns/1ns

module link_controller
	import link_pkg::*;
	import uart_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic want_at,
	input logic access_datastreams,
	input stream_head_t stream_head,
	input at_head_t at_head,
	input cycle_count_t cycles_per_bit,
	input cycle_count_t gap_cycles,
	output logic stream_pop,
	output logic at_pop,
	output logic fpga_txd
);

	typedef enum logic [2:0]
	{
		IDLE,
		LOAD,
		SEND,
		GAP,
		SECOND
	} state_t;

	state_t state;
	state_t state_next;
	sample_t hold;
	logic low_pending;
	cycle_count_t gap_cnt;
	logic gap_over;
	logic take_at;
	logic take_stream;
	logic tx_start;
	logic tx_done;
	tx_byte_t tx_byte;

	// Source choice, AT path has priority whenever requested
	assign take_at = (state == IDLE) && want_at && at_head.batch_ready && at_head.present;
	assign take_stream = (state == IDLE) && !want_at && access_datastreams
		&& stream_head.present;

	assign at_pop = take_at;
	assign stream_pop = take_stream;

	assign gap_over = (gap_cnt >= gap_cycles);

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
			begin
				if (take_at || take_stream)
					state_next = LOAD;
			end
			LOAD:
			begin
				state_next = SEND;
			end
			SEND:
			begin
				if (tx_done)
					state_next = GAP;
			end
			GAP:
			begin
				if (gap_over)
				begin
					if (low_pending)
						state_next = SECOND;
					else
						state_next = IDLE;
				end
			end
			SECOND:
			begin
				state_next = SEND;
			end
			default:
			begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			low_pending <= 1'b0;
			gap_cnt <= '0;
		end
		else
		begin
			state <= state_next;

			// Low byte still owed for a stream sample
			if (take_stream)
				low_pending <= 1'b1;
			else if (take_at || (state == SECOND))
				low_pending <= 1'b0;

			if (state == GAP)
				gap_cnt <= gap_cnt + 1'b1;
			else
				gap_cnt <= '0;
		end
	end

	// AT character rides in the high byte
	always_ff @(posedge clock)
	begin
		if (take_stream)
			hold <= stream_head.data;
		else if (take_at)
			hold <= {at_head.char, 8'h00};
	end

	assign tx_start = (state == LOAD) || (state == SECOND);
	assign tx_byte = (state == SECOND) ? hold[7:0] : hold[15:8];

	uart_tx u_tx
	(
		.clock(clock),
		.reset(reset),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.cycles_per_bit(cycles_per_bit),
		.fpga_txd(fpga_txd),
		.tx_done(tx_done)
	);

endmodule

// File: logic/link_pkg.sv
package link_pkg;

	// Stream side
	localparam int NUM_STREAMS = 8;
	localparam int STREAM_DEPTH = 4;
	localparam int STREAM_PTR_W = $clog2(STREAM_DEPTH);
	localparam int STREAM_CNT_W = $clog2(STREAM_DEPTH + 1);

	// Command side
	localparam int AT_DEPTH = 16;
	localparam int AT_PTR_W = $clog2(AT_DEPTH);
	localparam int AT_CNT_W = $clog2(AT_DEPTH + 1);

	typedef logic [15:0] sample_t;
	typedef logic [NUM_STREAMS-1:0] stream_mask_t;
	typedef logic [$clog2(NUM_STREAMS)-1:0] stream_idx_t;

	// Oldest sample of the selected stream
	typedef struct packed
	{
		logic present;
		sample_t data;
	} stream_head_t;

	// Oldest AT character, plus release state of the batch
	typedef struct packed
	{
		logic present;
		logic batch_ready;
		logic [7:0] char;
	} at_head_t;

endpackage

// File: logic/stream_buffer.sv
`timescale 1ns/1ns

module stream_buffer
	import link_pkg::*;
(
	input logic clock,
	input logic reset,
	input stream_mask_t stream_valid,
	input sample_t stream_data [NUM_STREAMS],
	input logic stream_pop,
	output stream_head_t stream_head
);

	sample_t fifo_mem [NUM_STREAMS][STREAM_DEPTH];
	logic [STREAM_PTR_W-1:0] wr_ptr [NUM_STREAMS];
	logic [STREAM_PTR_W-1:0] rd_ptr [NUM_STREAMS];
	logic [STREAM_CNT_W-1:0] count [NUM_STREAMS];
	logic [STREAM_CNT_W-1:0] count_next [NUM_STREAMS];
	stream_mask_t push;
	stream_mask_t pop;
	stream_idx_t sel;
	stream_idx_t next_sel;
	stream_idx_t cand;
	logic found;

	// Per-stream write and read enables
	always_comb
	begin
		for (int i = 0; i < NUM_STREAMS; i++)
		begin
			push[i] = stream_valid[i] && (count[i] != STREAM_CNT_W'(STREAM_DEPTH));
			pop[i] = stream_pop && (sel == stream_idx_t'(i)) && (count[i] != '0);
			count_next[i] = count[i] + STREAM_CNT_W'(push[i]) - STREAM_CNT_W'(pop[i]);
		end
	end

	// Search upward from the current stream, the current one last
	always_comb
	begin
		next_sel = sel;
		found = 1'b0;
		cand = sel;
		for (int i = 1; i <= NUM_STREAMS; i++)
		begin
			cand = sel + stream_idx_t'(i);
			if (!found && (count_next[cand] != '0))
			begin
				next_sel = cand;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			sel <= '0;
			for (int i = 0; i < NUM_STREAMS; i++)
			begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				count[i] <= '0;
			end
		end
		else
		begin
			// Move on after a pop, or when parked on an empty stream
			if (stream_pop || (count[sel] == '0))
				sel <= next_sel;
			for (int i = 0; i < NUM_STREAMS; i++)
			begin
				if (push[i])
					wr_ptr[i] <= wr_ptr[i] + 1'b1;
				if (pop[i])
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
				count[i] <= count_next[i];
			end
		end
	end

	// Sample storage
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < NUM_STREAMS; i++)
		begin
			if (push[i])
				fifo_mem[i][wr_ptr[i]] <= stream_data[i];
		end
	end

	assign stream_head.present = (count[sel] != '0);
	assign stream_head.data = fifo_mem[sel][rd_ptr[sel]];

endmodule

// File: logic/uart_pkg.sv
package uart_pkg;

	// Start bit, eight data bits LSB first, stop bit
	localparam int FRAME_BITS = 10;
	localparam int BIT_IDX_W = $clog2(FRAME_BITS);

	typedef logic [7:0] tx_byte_t;

	// Bit period and gap length, in clock cycles
	typedef logic [9:0] cycle_count_t;

endpackage

// File: logic/uart_tx.sv
`timescale 1ns/1ns

module uart_tx
	import uart_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic tx_start,
	input tx_byte_t tx_byte,
	input cycle_count_t cycles_per_bit,
	output logic fpga_txd,
	output logic tx_done
);

	logic busy;
	logic [BIT_IDX_W-1:0] bit_idx;
	cycle_count_t cyc_cnt;
	logic [8:0] shift;
	logic bit_end;
	logic start_ok;

	// Start only from idle
	assign start_ok = tx_start && !busy;
	assign bit_end = busy && (cyc_cnt == cycles_per_bit - 1'b1);

	// Last cycle of the stop bit
	assign tx_done = bit_end && (bit_idx == BIT_IDX_W'(FRAME_BITS - 1));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			bit_idx <= '0;
			cyc_cnt <= '0;
			fpga_txd <= 1'b1;
		end
		else if (start_ok)
		begin
			busy <= 1'b1;
			bit_idx <= '0;
			cyc_cnt <= '0;
			fpga_txd <= 1'b0;
		end
		else if (busy)
		begin
			if (bit_end)
			begin
				cyc_cnt <= '0;
				if (tx_done)
				begin
					busy <= 1'b0;
					fpga_txd <= 1'b1;
				end
				else
				begin
					bit_idx <= bit_idx + 1'b1;
					fpga_txd <= shift[0];
				end
			end
			else
				cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

	// Data bits then stop bit, shifted out LSB first
	always_ff @(posedge clock)
	begin
		if (start_ok)
			shift <= {1'b1, tx_byte};
		else if (bit_end)
			shift <= {1'b1, shift[8:1]};
	end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module bt_link_tb -f bt_link_top.f -o bt_link_sim
./obj_dir/bt_link_sim | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
	exit 0
else
	exit 1
fi
